// ==== hw/clkrst_pkg.sv ====
package clkrst_pkg;

	// --------------------
	// divider
	// --------------------

	// free-running T-cycle divider, upper byte is visible at FF04
	localparam int DIV_W = 16;

	// offset of the divider register inside the FF04-FF07 window
	localparam logic [1:0] DIV_REG_OFS = 2'd0;

	// tap strobes come from falling edges of these bits
	localparam int TAP_16K  = 7;
	localparam int TAP_64K  = 5;
	localparam int TAP_256K = 3;

	// --------------------
	// reset and sequencing
	// --------------------

	// first rise of this bit ends the power-on hold, 1024 T-cycles
	localparam int RST_TAP = 10;

	// T-cycles per machine cycle
	localparam int PHASES = 4;

	// audio frame divider source, 512 Hz normally and bit 2 in fast test mode
	localparam int APU_TAP      = 12;
	localparam int APU_FAST_TAP = 2;

endpackage

// ==== hw/phase_gen.sv ====
`timescale 1ns/100ps

module phase_gen (
	input  logic       clkin,
	input  logic       arst_n,
	input  logic       sys_rst_n,
	input  logic       cpu_rd,
	output logic [1:0] phase,
	output logic       mcyc_en,
	output logic       cpu_rd_sync
);
	import clkrst_pkg::*;

	localparam int PHASE_LAST = PHASES - 1;

	logic [1:0] phase_d;
	logic       rd_q;

	// --------------------
	// phase ring
	// --------------------

	// the four flops of the old ring collapse into a wrapping counter
	always_comb begin
		if (!sys_rst_n) begin
			phase_d = 2'd0;
		end else if (phase == 2'(PHASE_LAST)) begin
			phase_d = 2'd0;
		end else begin
			phase_d = phase + 2'd1;
		end
	end

	// mcyc_en is decoded from the next phase so it lines up with phase 3
	always_ff @(posedge clkin or negedge arst_n) begin
		if (!arst_n) begin
			phase   <= 2'd0;
			mcyc_en <= 1'b0;
		end else begin
			phase   <= phase_d;
			mcyc_en <= (phase_d == 2'(PHASE_LAST));
		end
	end

	// --------------------
	// read strobe
	// --------------------

	always_ff @(posedge clkin or negedge arst_n) begin
		if (!arst_n) begin
			rd_q <= 1'b0;
		end else begin
			rd_q <= cpu_rd;
		end
	end

	// the bus only sees a read in the second half of the machine cycle
	assign cpu_rd_sync = rd_q && (phase >= 2'(PHASES / 2));

	mcyc_phase_a: assert property (@(posedge clkin) disable iff (!arst_n)
		mcyc_en == (phase == 2'(PHASE_LAST)));

endmodule

// ==== hw/div_counter.sv ====
`timescale 1ns/100ps

module div_counter (
	input  logic                        clkin,
	input  logic                        arst_n,
	input  logic                        reset,
	input  logic                        reg_sel,
	input  logic [1:0]                  addr_lo,
	input  logic                        cpu_rd,
	input  logic                        cpu_wr,
	output logic [clkrst_pkg::DIV_W-1:0] div_q,
	output logic [7:0]                  rd_data,
	output logic                        rd_oe,
	output logic                        tick_16k,
	output logic                        tick_64k,
	output logic                        tick_256k
);
	import clkrst_pkg::*;

	logic       reg_hit;
	logic       wr_hit;
	logic       div_clr;
	logic [2:0] tap_now;
	logic [2:0] tap_q;

	// --------------------
	// register access
	// --------------------

	assign reg_hit = reg_sel && (addr_lo == DIV_REG_OFS);
	assign wr_hit  = reg_hit && cpu_wr;

	// any write to FF04 clears the whole divider, the data is ignored
	assign div_clr = reset || wr_hit;

	// only the upper byte is visible to the CPU
	assign rd_oe   = reg_hit && cpu_rd;
	assign rd_data = rd_oe ? div_q[DIV_W-1 -: 8] : 8'h00;

	// --------------------
	// counter
	// --------------------

	always_ff @(posedge clkin or negedge arst_n) begin
		if (!arst_n) begin
			div_q <= '0;
		end else if (div_clr) begin
			div_q <= '0;
		end else begin
			div_q <= div_q + DIV_W'(1);
		end
	end

	// --------------------
	// tap strobes
	// --------------------

	assign tap_now = {div_q[TAP_16K], div_q[TAP_64K], div_q[TAP_256K]};

	// a clear while a tap bit is high also counts as a fall
	always_ff @(posedge clkin or negedge arst_n) begin
		if (!arst_n) begin
			tap_q                            <= 3'b000;
			{tick_16k, tick_64k, tick_256k} <= 3'b000;
		end else begin
			tap_q                            <= tap_now;
			{tick_16k, tick_64k, tick_256k} <= tap_q & ~tap_now;
		end
	end

	div_clear_a: assert property (@(posedge clkin) disable iff (!arst_n)
		wr_hit |=> (div_q == '0));

endmodule

// ==== hw/reset_seq.sv ====
`timescale 1ns/100ps

module reset_seq (
	input  logic                        clkin,
	input  logic                        arst_n,
	input  logic                        reset,
	input  logic                        test_mode,
	input  logic                        lcd_on,
	input  logic [clkrst_pkg::DIV_W-1:0] div_q,
	output logic                        sys_rst_n,
	output logic                        video_rst_n
);
	import clkrst_pkg::*;

	logic release_set;
	logic video_d;

	// --------------------
	// system reset
	// --------------------

	// wait for the divider to reach the tap so the oscillator has settled,
	// test mode skips the wait
	assign release_set = test_mode || div_q[RST_TAP];

	// sticky, later divider wraps or FF04 writes must not re-enter reset
	always_ff @(posedge clkin or negedge arst_n) begin
		if (!arst_n) begin
			sys_rst_n <= 1'b0;
		end else if (reset) begin
			sys_rst_n <= 1'b0;
		end else if (release_set) begin
			sys_rst_n <= 1'b1;
		end
	end

	// --------------------
	// video reset
	// --------------------

	// reset also drops video at the same edge as the system reset
	assign video_d = sys_rst_n && lcd_on && !reset;

	always_ff @(posedge clkin or negedge arst_n) begin
		if (!arst_n) begin
			video_rst_n <= 1'b0;
		end else begin
			video_rst_n <= video_d;
		end
	end

	video_in_sys_a: assert property (@(posedge clkin) disable iff (!arst_n)
		video_rst_n |-> sys_rst_n);

endmodule

// ==== hw/apu_frame_div.sv ====
`timescale 1ns/100ps

module apu_frame_div (
	input  logic                        clkin,
	input  logic                        arst_n,
	input  logic                        sys_rst_n,
	input  logic                        apu_on,
	input  logic                        apu_fast,
	input  logic [clkrst_pkg::DIV_W-1:0] div_q,
	output logic                        frame_512,
	output logic                        frame_256,
	output logic                        frame_128
);
	import clkrst_pkg::*;

	logic       tap_sel;
	logic       tap_q;
	logic       tap_fall;
	logic [2:0] frame_cnt;

	// fast mode takes a much quicker divider bit for production test
	assign tap_sel = apu_fast ? div_q[APU_FAST_TAP] : div_q[APU_TAP];

	// --------------------
	// edge detect
	// --------------------

	always_ff @(posedge clkin or negedge arst_n) begin
		if (!arst_n) begin
			tap_q <= 1'b0;
		end else begin
			tap_q <= tap_sel;
		end
	end

	assign tap_fall = tap_q && !tap_sel;

	// the three ripple stages of the original behave as one binary count
	always_ff @(posedge clkin or negedge arst_n) begin
		if (!arst_n) begin
			frame_cnt <= 3'd0;
		end else if (!apu_on || !sys_rst_n) begin
			frame_cnt <= 3'd0;
		end else if (tap_fall) begin
			frame_cnt <= frame_cnt + 3'd1;
		end
	end

	// each stage halves the one before it
	assign frame_512 = frame_cnt[0];
	assign frame_256 = frame_cnt[1];
	assign frame_128 = frame_cnt[2];

endmodule

// ==== hw/clock_reset.sv ====
`timescale 1ns/100ps

module clock_reset (
	input  logic       clkin,
	input  logic       arst_n,
	input  logic       reset,
	input  logic       test_mode,
	input  logic       cpu_rd,
	input  logic       cpu_wr,
	input  logic       reg_sel,
	input  logic [1:0] addr_lo,
	input  logic [7:0] wr_data,
	input  logic       lcd_on,
	input  logic       apu_on,
	input  logic       apu_fast,
	output logic [1:0] phase,
	output logic       mcyc_en,
	output logic       cpu_rd_sync,
	output logic       sys_rst_n,
	output logic       video_rst_n,
	output logic [7:0] rd_data,
	output logic       rd_oe,
	output logic       tick_16k,
	output logic       tick_64k,
	output logic       tick_256k,
	output logic       frame_512,
	output logic       frame_256,
	output logic       frame_128
);
	import clkrst_pkg::*;

	logic [DIV_W-1:0] div_q;

	phase_gen phase_gen_i (
		.clkin       (clkin),
		.arst_n      (arst_n),
		.sys_rst_n   (sys_rst_n),
		.cpu_rd      (cpu_rd),
		.phase       (phase),
		.mcyc_en     (mcyc_en),
		.cpu_rd_sync (cpu_rd_sync)
	);

	div_counter div_counter_i (
		.clkin     (clkin),
		.arst_n    (arst_n),
		.reset     (reset),
		.reg_sel   (reg_sel),
		.addr_lo   (addr_lo),
		.cpu_rd    (cpu_rd),
		.cpu_wr    (cpu_wr),
		.div_q     (div_q),
		.rd_data   (rd_data),
		.rd_oe     (rd_oe),
		.tick_16k  (tick_16k),
		.tick_64k  (tick_64k),
		.tick_256k (tick_256k)
	);

	reset_seq reset_seq_i (
		.clkin       (clkin),
		.arst_n      (arst_n),
		.reset       (reset),
		.test_mode   (test_mode),
		.lcd_on      (lcd_on),
		.div_q       (div_q),
		.sys_rst_n   (sys_rst_n),
		.video_rst_n (video_rst_n)
	);

	apu_frame_div apu_frame_div_i (
		.clkin     (clkin),
		.arst_n    (arst_n),
		.sys_rst_n (sys_rst_n),
		.apu_on    (apu_on),
		.apu_fast  (apu_fast),
		.div_q     (div_q),
		.frame_512 (frame_512),
		.frame_256 (frame_256),
		.frame_128 (frame_128)
	);

endmodule

// ==== testbench/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen #(
	parameter int PERIOD_NS  = 100,
	parameter int RST_CYCLES = 5
) (
	output logic clkin,
	output logic arst_n
);

	initial begin
		clkin = 1'b0;
		forever #(PERIOD_NS / 2) clkin = ~clkin;
	end

	// release away from the edge so no flop sees it together with the clock
	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clkin);
		#10;
		arst_n = 1'b1;
	end

endmodule

// ==== testbench/tb_clock_reset.sv ====
`timescale 1ns/100ps

module tb_clock_reset;
	import clkrst_pkg::*;

	localparam int DRIVE_DLY   = 10;
	localparam int SETTLE_DLY  = 20;
	localparam int RAND_SEED   = 60934;
	localparam int TICK_WINDOW = 1024;
	localparam int APU_RUN     = 120;
	// rough length of each test in cycles, the run stops at 1.5 times their sum
	localparam int TEST_CYCLES = (1 << RST_TAP) + 20 + 8400 + 50 + 40 + APU_RUN + 20;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

	logic       clkin, arst_n, reset, test_mode, cpu_rd, cpu_wr, reg_sel;
	logic [1:0] addr_lo, phase;
	logic [7:0] wr_data, rd_data;
	logic       lcd_on, apu_on, apu_fast, mcyc_en, cpu_rd_sync;
	logic       sys_rst_n, video_rst_n, rd_oe, tick_16k, tick_64k, tick_256k;
	logic       frame_512, frame_256, frame_128;
	int         chk_cnt;
	int         err_cnt;
	int unsigned cycle_cnt;

	tb_clkgen clkgen_i (.clkin(clkin), .arst_n(arst_n));

	clock_reset dut_i (
		.clkin(clkin), .arst_n(arst_n), .reset(reset), .test_mode(test_mode),
		.cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .reg_sel(reg_sel), .addr_lo(addr_lo),
		.wr_data(wr_data), .lcd_on(lcd_on), .apu_on(apu_on), .apu_fast(apu_fast),
		.phase(phase), .mcyc_en(mcyc_en), .cpu_rd_sync(cpu_rd_sync),
		.sys_rst_n(sys_rst_n), .video_rst_n(video_rst_n), .rd_data(rd_data),
		.rd_oe(rd_oe), .tick_16k(tick_16k), .tick_64k(tick_64k), .tick_256k(tick_256k),
		.frame_512(frame_512), .frame_256(frame_256), .frame_128(frame_128)
	);

	// --------------------
	// compare tasks
	// --------------------

	task automatic check_bit(input string name, input logic exp, input logic act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("FAILED %s: expected %0b, actual %0b", name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("FAILED %s: expected %02h, actual %02h", name, exp, act);
		end
	endtask

	task automatic check_phase(input string name, input logic [1:0] exp, input logic [1:0] act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("FAILED %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// --------------------
	// stimulus helpers
	// --------------------

	task automatic next_cycle();
		@(posedge clkin);
		#DRIVE_DLY;
	endtask

	// returns right after reset is driven low, the divider is 0 at that point
	task automatic start_from_reset(input logic tmode);
		reset     = 1'b1;
		test_mode = tmode;
		repeat (2) next_cycle();
		reset = 1'b0;
	endtask

	task automatic read_div(input string name, input logic [7:0] exp);
		reg_sel = 1'b1;
		addr_lo = DIV_REG_OFS;
		cpu_rd  = 1'b1;
		#SETTLE_DLY;
		check_bit({name, "_oe"}, 1'b1, rd_oe);
		check_byte(name, exp, rd_data);
		next_cycle();
		reg_sel = 1'b0;
		cpu_rd  = 1'b0;
		#SETTLE_DLY;
		check_bit({name, "_oe_idle"}, 1'b0, rd_oe);
		next_cycle();
	endtask

	task automatic write_div();
		reg_sel = 1'b1;
		addr_lo = DIV_REG_OFS;
		cpu_wr  = 1'b1;
		wr_data = 8'($urandom);
		next_cycle();
		reg_sel = 1'b0;
		cpu_wr  = 1'b0;
	endtask

	// --------------------
	// tests
	// --------------------

	task automatic test_reset_hold();
		logic [15:0] div_m;
		logic        sys_exp;
		div_m   = '0;
		sys_exp = 1'b0;
		lcd_on  = 1'b1;
		start_from_reset(1'b0);
		for (int k = 1; k <= (1 << RST_TAP) + 2; k++) begin
			// release happens at the edge that sees the tap bit already set
			if (div_m[RST_TAP])
				sys_exp = 1'b1;
			div_m++;
			next_cycle();
			check_bit("reset_hold", sys_exp, sys_rst_n);
			if (!sys_rst_n)
				check_bit("video_low_in_reset", 1'b0, video_rst_n);
		end
		check_bit("video_after_release", 1'b1, video_rst_n);
		start_from_reset(1'b1);
		check_bit("test_mode_hold", 1'b0, sys_rst_n);
		next_cycle();
		check_bit("test_mode_release", 1'b1, sys_rst_n);
		test_mode = 1'b0;
		lcd_on    = 1'b0;
	endtask

	task automatic test_div_read_clear();
		int unsigned n;
		int unsigned n2;
		int          cnt_16k, cnt_64k, cnt_256k;
		cnt_16k  = 0;
		cnt_64k  = 0;
		cnt_256k = 0;
		start_from_reset(1'b0);
		n = 300 + ($urandom % 2700);
		repeat (n) next_cycle();
		read_div("div_read", 8'((n % 65536) >> 8));
		repeat (1 + ($urandom % 200)) next_cycle();
		write_div();
		n2 = 256 + ($urandom % 3800);
		repeat (n2) next_cycle();
		read_div("div_after_clear", 8'(n2 >> 8));
		write_div();
		// the first cycle can carry a tick made by the clear itself
		for (int k = 1; k <= TICK_WINDOW + 1; k++) begin
			next_cycle();
			if (k >= 2) begin
				cnt_16k  += int'(tick_16k);
				cnt_64k  += int'(tick_64k);
				cnt_256k += int'(tick_256k);
			end
		end
		check_byte("tick_16k_count", 8'(TICK_WINDOW >> (TAP_16K + 1)), 8'(cnt_16k));
		check_byte("tick_64k_count", 8'(TICK_WINDOW >> (TAP_64K + 1)), 8'(cnt_64k));
		check_byte("tick_256k_count", 8'(TICK_WINDOW >> (TAP_256K + 1)), 8'(cnt_256k));
	endtask

	task automatic test_phase_seq();
		logic [1:0] ph_exp;
		logic       sys_m;
		logic       rd_now;
		ph_exp = 2'd0;
		sys_m  = 1'b0;
		start_from_reset(1'b1);
		check_phase("phase_in_reset", 2'd0, phase);
		for (int k = 1; k <= 40; k++) begin
			rd_now = cpu_rd;
			ph_exp = sys_m ? ph_exp + 2'd1 : 2'd0;
			sys_m  = 1'b1;
			next_cycle();
			check_phase("phase_seq", ph_exp, phase);
			check_bit("mcyc_en", ph_exp == 2'd3, mcyc_en);
			check_bit("cpu_rd_sync", rd_now && (ph_exp >= 2'd2), cpu_rd_sync);
			cpu_rd = (k >= 10) && (k < 26);
		end
		cpu_rd = 1'b0;
	endtask

	task automatic test_video_reset();
		logic sys_m;
		logic vid_exp;
		sys_m  = 1'b0;
		lcd_on = 1'b1;
		start_from_reset(1'b1);
		check_bit("video_in_reset", 1'b0, video_rst_n);
		for (int k = 1; k <= 30; k++) begin
			vid_exp = sys_m && lcd_on;
			sys_m   = 1'b1;
			next_cycle();
			check_bit("video_follow_lcd", vid_exp, video_rst_n);
			lcd_on = (k % 7) >= 3;
		end
		lcd_on = 1'b0;
	endtask

	task automatic test_apu_frame();
		logic [15:0] div_m, div_prev;
		logic [2:0]  cnt_exp;
		logic        sys_m;
		logic        fall;
		int          on_at;
		div_m    = '0;
		div_prev = '0;
		cnt_exp  = 3'd0;
		sys_m    = 1'b0;
		on_at    = 3 + int'($urandom % 8);
		apu_on   = 1'b0;
		apu_fast = 1'b1;
		start_from_reset(1'b1);
		for (int k = 1; k <= APU_RUN; k++) begin
			fall = div_prev[APU_FAST_TAP] && !div_m[APU_FAST_TAP];
			if (!apu_on || !sys_m)
				cnt_exp = 3'd0;
			else if (fall)
				cnt_exp++;
			sys_m    = 1'b1;
			div_prev = div_m;
			div_m++;
			next_cycle();
			check_bit("frame_512", cnt_exp[0], frame_512);
			check_bit("frame_256", cnt_exp[1], frame_256);
			check_bit("frame_128", cnt_exp[2], frame_128);
			if (k == on_at)
				apu_on = 1'b1;
			if (k == APU_RUN - 10)
				apu_on = 1'b0;
		end
		check_byte("frame_cleared", 8'd0, {5'd0, frame_128, frame_256, frame_512});
		apu_fast = 1'b0;
	endtask

	// --------------------
	// run control
	// --------------------

	always @(posedge clkin) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		void'($urandom(RAND_SEED));
		chk_cnt   = 0;
		err_cnt   = 0;
		cycle_cnt = 0;
		reset     = 1'b1;
		test_mode = 1'b0;
		cpu_rd    = 1'b0;
		cpu_wr    = 1'b0;
		reg_sel   = 1'b0;
		addr_lo   = 2'd0;
		wr_data   = 8'h00;
		lcd_on    = 1'b0;
		apu_on    = 1'b0;
		apu_fast  = 1'b0;
		@(posedge arst_n);
		next_cycle();
		test_reset_hold();
		test_div_read_clear();
		test_phase_seq();
		test_video_reset();
		test_apu_frame();
		$display("checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== clock_reset.f ====
hw/clkrst_pkg.sv
hw/phase_gen.sv
hw/div_counter.sv
hw/reset_seq.sv
hw/apu_frame_div.sv
hw/clock_reset.sv
testbench/tb_clkgen.sv
testbench/tb_clock_reset.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_clock_reset
FILELIST  ?= clock_reset.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
